// File: Makefile
# Verilator build and run of the privilege unit testbench

VERILATOR ?= verilator
TOP       ?= privUnitTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: filelist.f
+incdir+hdl
hdl/privTypesPkg.sv
hdl/csrMapPkg.sv
hdl/trap.sv
hdl/intInputs.sv
hdl/csrFile.sv
hdl/privUnit.sv
test/clockGen.sv
test/privUnitTb.sv

// File: hdl/csrFile.sv
/*
  trap CSR file
  holds the machine and supervisor trap CSRs, serves host accesses
  over a four-phase req/ack port, updates state on trap entry and
  xret and forms the redirect PC
*/
`timescale 1ns/100ps
`include "priv_defs.svh"

module csrFile (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     csrReq,
  input  csrMapPkg::csrAddrT       csrAddr,
  input  logic                     csrWrite,
  input  logic [`XLEN_P-1:0]       csrWdata,
  output logic                     csrAck,
  output logic [`XLEN_P-1:0]       csrRdata,
  input  logic [11:0]              mipExt,
  input  logic                     trapM, interruptM, delegateM,
  input  privTypesPkg::causeT      causeM,
  input  logic [`XLEN_P-1:0]       pcM,
  input  logic                     mretM, sretM,
  output logic [11:0]              mipReg, mieReg, midelegReg,
  output logic [15:0]              medelegReg,
  output logic                     statusMie, statusSie,
  output privTypesPkg::privModeT   privMode,
  output logic                     redirect,
  output logic [`XLEN_P-1:0]       redirectPc
);
  import privTypesPkg::*;
  import csrMapPkg::*;

  localparam int          XL           = `XLEN_P;
  localparam bit          SUP_ON       = (`S_SUPPORTED != 0);
  localparam logic [11:0] MIE_MASK     = 12'haaa;                      // the six int bits
  localparam logic [11:0] MIP_SW_MASK  = SUP_ON ? 12'h222 : 12'h000;   // SSIP, STIP, SEIP
  localparam logic [11:0] MIDELEG_MASK = SUP_ON ? 12'h222 : 12'h000;
  localparam logic [15:0] MEDELEG_MASK = SUP_ON ? 16'hb3ff : 16'h0000; // no ecall-M, reserved

  logic             statusMpie, statusSpie, statusSpp;
  privModeT         statusMpp;
  logic [11:0]      mipSw;                        // software-set pending bits
  logic [XL-1:0]    mtvec, stvec, mepc, sepc, mcause, scause;
  logic [XL-1:0]    statusVal, readVal, tvec, tvecBase;
  logic             accPend, doAccess;             // request seen, waiting to be serviced

  assign mipReg   = mipExt | mipSw;
  assign doAccess = accPend & ~trapM;             // trap updates win the edge

  ////////////////////////////////////////////////////////////////////
  // redirect target
  ////////////////////////////////////////////////////////////////////
  assign redirect = trapM | mretM | sretM;
  assign tvec     = delegateM ? stvec : mtvec;
  assign tvecBase = {tvec[XL-1:2], 2'b00};

  always_comb begin
    if (trapM) begin
      if (interruptM & tvec[0]) redirectPc = tvecBase + {{(XL-6){1'b0}}, causeM, 2'b00}; // vectored
      else                      redirectPc = tvecBase;
    end else if (mretM) redirectPc = mepc;
    else                redirectPc = sepc;
  end

  // mstatus view and read mux
  always_comb begin
    statusVal                    = '0;
    statusVal[MSTATUS_SIE]       = statusSie;
    statusVal[MSTATUS_MIE]       = statusMie;
    statusVal[MSTATUS_SPIE]      = statusSpie;
    statusVal[MSTATUS_MPIE]      = statusMpie;
    statusVal[MSTATUS_SPP]       = statusSpp;
    statusVal[MSTATUS_MPP +: 2]  = statusMpp;
    case (csrAddr)
      CSR_MSTATUS: readVal = statusVal;
      CSR_MEDELEG: readVal = {{(XL-16){1'b0}}, medelegReg};
      CSR_MIDELEG: readVal = {{(XL-12){1'b0}}, midelegReg};
      CSR_MIE:     readVal = {{(XL-12){1'b0}}, mieReg};
      CSR_MIP:     readVal = {{(XL-12){1'b0}}, mipReg};
      CSR_MTVEC:   readVal = mtvec;
      CSR_MEPC:    readVal = mepc;
      CSR_MCAUSE:  readVal = mcause;
      CSR_STVEC:   readVal = stvec;
      CSR_SEPC:    readVal = sepc;
      CSR_SCAUSE:  readVal = scause;
      default:     readVal = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // state updates: trap, then xret, then host port
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      {statusMie, statusSie, statusMpie, statusSpie, statusSpp} <= '0;
      statusMpp  <= U_MODE;
      privMode   <= M_MODE;
      {mieReg, mipSw, midelegReg, medelegReg} <= '0;
      {mtvec, stvec, mepc, sepc, mcause, scause} <= '0;
      accPend    <= 1'b0;
      csrAck     <= 1'b0;
    end else begin
      if (trapM & delegateM) begin           // supervisor entry
        sepc       <= pcM;
        scause     <= {interruptM, {(XL-5){1'b0}}, causeM};
        statusSpie <= statusSie;
        statusSie  <= 1'b0;
        statusSpp  <= (privMode == S_MODE);
        privMode   <= S_MODE;
      end else if (trapM) begin              // machine entry
        mepc       <= pcM;
        mcause     <= {interruptM, {(XL-5){1'b0}}, causeM};
        statusMpie <= statusMie;
        statusMie  <= 1'b0;
        statusMpp  <= privMode;
        privMode   <= M_MODE;
      end else if (mretM) begin
        privMode   <= statusMpp;
        statusMie  <= statusMpie;
        statusMpie <= 1'b0;
        statusMpp  <= U_MODE;
      end else if (sretM) begin
        privMode   <= statusSpp ? S_MODE : U_MODE;
        statusSie  <= statusSpie;
        statusSpie <= 1'b0;
        statusSpp  <= 1'b0;
      end

      // four-phase handshake
      if (csrReq & ~csrAck & ~accPend) accPend <= 1'b1;
      else if (doAccess) begin
        accPend <= 1'b0;
        csrAck  <= 1'b1;
      end else if (csrAck & ~csrReq) csrAck <= 1'b0; // host let go

      if (doAccess & csrWrite) begin
        case (csrAddr)
          CSR_MSTATUS: begin
            statusSie  <= csrWdata[MSTATUS_SIE] & SUP_ON;
            statusMie  <= csrWdata[MSTATUS_MIE];
            statusSpie <= csrWdata[MSTATUS_SPIE] & SUP_ON;
            statusMpie <= csrWdata[MSTATUS_MPIE];
            statusSpp  <= csrWdata[MSTATUS_SPP] & SUP_ON;
            statusMpp  <= privModeT'(csrWdata[MSTATUS_MPP +: 2]);
          end
          CSR_MEDELEG: medelegReg <= csrWdata[15:0] & MEDELEG_MASK;
          CSR_MIDELEG: midelegReg <= csrWdata[11:0] & MIDELEG_MASK;
          CSR_MIE:     mieReg     <= csrWdata[11:0] & MIE_MASK;
          CSR_MIP:     mipSw      <= csrWdata[11:0] & MIP_SW_MASK;
          CSR_MTVEC:   mtvec      <= {csrWdata[XL-1:2], 1'b0, csrWdata[0]}; // bit 1 reserved
          CSR_STVEC:   stvec      <= {csrWdata[XL-1:2], 1'b0, csrWdata[0]};
          CSR_MEPC:    mepc       <= {csrWdata[XL-1:2], 2'b00};
          CSR_SEPC:    sepc       <= {csrWdata[XL-1:2], 2'b00};
          CSR_MCAUSE:  mcause     <= csrWdata;
          CSR_SCAUSE:  scause     <= csrWdata;
          default: ;
        endcase
      end
    end
  end

  // read data, value before any write of the same access
  always_ff @(posedge clk) begin
    if (doAccess) csrRdata <= readVal;
  end

endmodule

// File: hdl/csrMapPkg.sv
/*
  CSR map
  addresses of the implemented trap CSRs and the bit positions
  of the mstatus fields kept by the CSR file
*/
package csrMapPkg;

  typedef logic [11:0] csrAddrT;

  ////////////////////////////////////////////////////////////////////
  // machine level
  ////////////////////////////////////////////////////////////////////
  localparam csrAddrT CSR_MSTATUS = 12'h300;
  localparam csrAddrT CSR_MEDELEG = 12'h302;
  localparam csrAddrT CSR_MIDELEG = 12'h303;
  localparam csrAddrT CSR_MIE     = 12'h304;
  localparam csrAddrT CSR_MTVEC   = 12'h305;
  localparam csrAddrT CSR_MEPC    = 12'h341;
  localparam csrAddrT CSR_MCAUSE  = 12'h342;
  localparam csrAddrT CSR_MIP     = 12'h344;

  // supervisor level
  localparam csrAddrT CSR_STVEC   = 12'h105;
  localparam csrAddrT CSR_SEPC    = 12'h141;
  localparam csrAddrT CSR_SCAUSE  = 12'h142;

  // mstatus field positions, MPP is two bits wide
  localparam int MSTATUS_SIE  = 1;
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_SPIE = 5;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_SPP  = 8;
  localparam int MSTATUS_MPP  = 11;

endpackage

// File: hdl/intInputs.sv
/*
  interrupt inputs
  two-flop synchronizers for the asynchronous interrupt lines,
  placed at their mip bit positions
*/
`timescale 1ns/100ps

module intInputs (
  input  logic        clk,
  input  logic        reset,
  input  logic        extIntM,   // platform external, machine
  input  logic        extIntS,   // platform external, supervisor
  input  logic        timerIntM, // mtime compare
  input  logic        softIntM,  // msip from the CLINT
  output logic [11:0] mipExt     // hardware-owned pending bits
);
  import privTypesPkg::*;

  logic [3:0] syncA, syncB; // first and second stage

  always_ff @(posedge clk) begin
    if (reset) begin
      syncA <= '0;
      syncB <= '0;
    end else begin
      syncA <= {extIntM, extIntS, timerIntM, softIntM};
      syncB <= syncA;
    end
  end

  // software bits are merged in the CSR file
  always_comb begin
    mipExt          = '0;
    mipExt[INT_MEI] = syncB[3];
    mipExt[INT_SEI] = syncB[2];
    mipExt[INT_MTI] = syncB[1];
    mipExt[INT_MSI] = syncB[0];
  end

endmodule

// File: hdl/privTypesPkg.sv
/*
  privilege types
  mode encoding, 4-bit trap cause code, interrupt bit indices and
  synchronous exception codes from the privileged spec
*/
package privTypesPkg;

  // privilege mode as held in mstatus.MPP and the mode register
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } privModeT;

  typedef logic [3:0] causeT; // mcause/scause code field

  ////////////////////////////////////////////////////////////////////
  // interrupt causes, also the bit index in mip/mie/mideleg
  ////////////////////////////////////////////////////////////////////
  localparam causeT INT_SSI = 4'd1;  // supervisor software
  localparam causeT INT_MSI = 4'd3;  // machine software
  localparam causeT INT_STI = 4'd5;  // supervisor timer
  localparam causeT INT_MTI = 4'd7;  // machine timer
  localparam causeT INT_SEI = 4'd9;  // supervisor external
  localparam causeT INT_MEI = 4'd11; // machine external

  ////////////////////////////////////////////////////////////////////
  // exception causes, 10 and 14 are reserved
  ////////////////////////////////////////////////////////////////////
  localparam causeT EXC_INSTR_MISALIGNED = 4'd0;
  localparam causeT EXC_INSTR_ACCESS     = 4'd1;
  localparam causeT EXC_ILLEGAL_INSTR    = 4'd2;
  localparam causeT EXC_BREAKPOINT       = 4'd3;
  localparam causeT EXC_LOAD_MISALIGNED  = 4'd4;
  localparam causeT EXC_LOAD_ACCESS      = 4'd5;
  localparam causeT EXC_STORE_MISALIGNED = 4'd6;
  localparam causeT EXC_STORE_ACCESS     = 4'd7;
  localparam causeT EXC_ECALL_U          = 4'd8;
  localparam causeT EXC_ECALL_S          = 4'd9;
  localparam causeT EXC_ECALL_M          = 4'd11;
  localparam causeT EXC_INSTR_PAGE       = 4'd12;
  localparam causeT EXC_LOAD_PAGE        = 4'd13;
  localparam causeT EXC_STORE_PAGE       = 4'd15;

endpackage

// File: hdl/privUnit.sv
/*
  privilege unit top
  interrupt synchronizers, M-stage trap decision and the trap CSR file
*/
`timescale 1ns/100ps
`include "priv_defs.svh"

module privUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrMisalignedFault, instrAccessFault, instrPageFault,
  input  logic                   illegalInstrFault, breakpointFault, ecallFault,
  input  logic                   loadMisalignedFault, storeMisalignedFault,
  input  logic                   loadAccessFault, storeAccessFault,
  input  logic                   loadPageFault, storePageFault,
  input  logic                   instrValidM, committedM, committedF, wfiM, wfiW,
  input  logic [`XLEN_P-1:0]     pcM,
  input  logic                   mretM, sretM,
  input  logic                   extIntM, extIntS, timerIntM, softIntM,
  input  logic                   csrReq,        // host port
  input  csrMapPkg::csrAddrT     csrAddr,
  input  logic                   csrWrite,
  input  logic [`XLEN_P-1:0]     csrWdata,
  output logic                   csrAck,
  output logic [`XLEN_P-1:0]     csrRdata,
  output logic                   trapM, interruptM, exceptionM, intPendingM, delegateM,
  output privTypesPkg::causeT    causeM,
  output logic                   redirect,
  output logic [`XLEN_P-1:0]     redirectPc,
  output privTypesPkg::privModeT privMode
);

  logic [11:0] mipExt;                              // synchronized hw pending bits
  logic [11:0] mipReg, mieReg, midelegReg;
  logic [15:0] medelegReg;
  logic        statusMie, statusSie;

  intInputs uIntInputs (
    .clk, .reset, .extIntM, .extIntS, .timerIntM, .softIntM, .mipExt
  );

  // combinational M-stage decision
  trap uTrap (
    .reset, .instrMisalignedFault, .instrAccessFault, .instrPageFault,
    .illegalInstrFault, .breakpointFault, .ecallFault,
    .loadMisalignedFault, .storeMisalignedFault, .loadAccessFault, .storeAccessFault,
    .loadPageFault, .storePageFault, .instrValidM, .committedM, .committedF,
    .wfiM, .wfiW, .privMode, .mipReg, .mieReg, .midelegReg, .medelegReg,
    .statusMie, .statusSie, .trapM, .interruptM, .exceptionM, .intPendingM,
    .delegateM, .causeM
  );

  csrFile uCsrFile (
    .clk, .reset, .csrReq, .csrAddr, .csrWrite, .csrWdata, .csrAck, .csrRdata,
    .mipExt, .trapM, .interruptM, .delegateM, .causeM, .pcM, .mretM, .sretM,
    .mipReg, .mieReg, .midelegReg, .medelegReg, .statusMie, .statusSie,
    .privMode, .redirect, .redirectPc
  );

endmodule

// File: hdl/priv_defs.svh
/*
  privilege unit build options
  datapath width and optional architecture features
  shared by the trap logic and the CSR file
*/
`ifndef PRIV_DEFS_SVH
`define PRIV_DEFS_SVH

// data and address width, only RV32 for now
`define XLEN_P 32

// supervisor mode present
// at 0 every delegation path is tied off
`define S_SUPPORTED 1

// misaligned loads and stores handled in hardware
// at 1 misaligned faults drop below page and access faults
`define ZICCLSM_SUPPORTED 0

`endif

// File: hdl/trap.sv
/*
  trap decision
  decides in the M stage whether an interrupt or exception is taken,
  picks the cause by privileged spec priority and whether the trap
  is delegated to the supervisor handler
*/
`timescale 1ns/100ps
`include "priv_defs.svh"

module trap (
  input  logic                   reset,
  input  logic                   instrMisalignedFault, instrAccessFault, instrPageFault,
  input  logic                   illegalInstrFault, breakpointFault, ecallFault,
  input  logic                   loadMisalignedFault, storeMisalignedFault,
  input  logic                   loadAccessFault, storeAccessFault,
  input  logic                   loadPageFault, storePageFault,
  input  logic                   instrValidM,            // M stage holds a real instruction
  input  logic                   committedM, committedF, // bus op under way, not interruptible
  input  logic                   wfiM, wfiW,
  input  privTypesPkg::privModeT privMode,
  input  logic [11:0]            mipReg, mieReg, midelegReg,
  input  logic [15:0]            medelegReg,
  input  logic                   statusMie, statusSie,
  output logic                   trapM,
  output logic                   interruptM,
  output logic                   exceptionM,
  output logic                   intPendingM,             // pending and enabled, even if masked
  output logic                   delegateM,               // goes to the S handler
  output privTypesPkg::causeT    causeM
);
  import privTypesPkg::*;

  localparam bit SUP_ON   = (`S_SUPPORTED != 0);
  localparam bit MIS_HIGH = (`ZICCLSM_SUPPORTED == 0); // misaligned always traps

  logic        mGlobalEn, sGlobalEn;
  logic [11:0] delegInts;             // mideleg, tied off without S mode
  logic [11:0] pendingInts, enabledInts, validInts;
  logic [15:0] delegVec;              // per-cause delegate bits
  causeT       ecallCause;

  //////////////////////////////////////////////////////////////////////
  // interrupt masking
  //////////////////////////////////////////////////////////////////////
  assign mGlobalEn   = (privMode != M_MODE) | statusMie; // lower modes always see M ints
  assign sGlobalEn   = (privMode == U_MODE) | ((privMode == S_MODE) & statusSie);
  assign delegInts   = SUP_ON ? midelegReg : 12'h000;
  assign pendingInts = mipReg & mieReg;
  assign intPendingM = |pendingInts;
  assign enabledInts = ({12{mGlobalEn}} & pendingInts & ~delegInts) |
                       ({12{sGlobalEn}} & pendingInts & delegInts);
  assign validInts   = {12{~(committedM | committedF)}} & enabledInts;

  // hold off until a wfi reaches W, and never on a flushed slot
  assign interruptM  = ~reset & (|validInts) & instrValidM & (~wfiM | wfiW);

  assign exceptionM  = instrMisalignedFault | instrAccessFault | instrPageFault |
                       illegalInstrFault | breakpointFault | ecallFault |
                       loadMisalignedFault | storeMisalignedFault |
                       loadAccessFault | storeAccessFault | loadPageFault | storePageFault;

  assign trapM       = ~reset & ((exceptionM & ~committedF) | interruptM);

  // delegation only from S or U, M traps never go down
  assign delegVec    = interruptM ? {4'h0, delegInts} : medelegReg;
  assign delegateM   = SUP_ON & delegVec[causeM] & (privMode != M_MODE);

  // ecall code is 8 plus the mode
  assign ecallCause  = (privMode == M_MODE) ? EXC_ECALL_M :
                       (privMode == S_MODE) ? EXC_ECALL_S : EXC_ECALL_U;

  //////////////////////////////////////////////////////////////////////
  // cause priority
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if      (reset)                              causeM = EXC_INSTR_MISALIGNED; // cause 0
    else if (validInts[INT_MEI])                 causeM = INT_MEI;
    else if (validInts[INT_MSI])                 causeM = INT_MSI;
    else if (validInts[INT_MTI])                 causeM = INT_MTI;
    else if (validInts[INT_SEI])                 causeM = INT_SEI;
    else if (validInts[INT_SSI])                 causeM = INT_SSI;
    else if (validInts[INT_STI])                 causeM = INT_STI;
    else if (instrPageFault)                     causeM = EXC_INSTR_PAGE;
    else if (instrAccessFault)                   causeM = EXC_INSTR_ACCESS;
    else if (illegalInstrFault)                  causeM = EXC_ILLEGAL_INSTR;
    else if (instrMisalignedFault)               causeM = EXC_INSTR_MISALIGNED;
    else if (breakpointFault)                    causeM = EXC_BREAKPOINT;
    else if (ecallFault)                         causeM = ecallCause;
    else if (storeMisalignedFault & MIS_HIGH)    causeM = EXC_STORE_MISALIGNED;
    else if (loadMisalignedFault & MIS_HIGH)     causeM = EXC_LOAD_MISALIGNED;
    else if (storePageFault)                     causeM = EXC_STORE_PAGE;
    else if (loadPageFault)                      causeM = EXC_LOAD_PAGE;
    else if (storeAccessFault)                   causeM = EXC_STORE_ACCESS;
    else if (loadAccessFault)                    causeM = EXC_LOAD_ACCESS;
    else if (storeMisalignedFault)               causeM = EXC_STORE_MISALIGNED; // hw-handled case
    else if (loadMisalignedFault)                causeM = EXC_LOAD_MISALIGNED;
    else                                         causeM = EXC_INSTR_MISALIGNED;
  end

endmodule

// File: test/clockGen.sv
/*
  testbench clock and reset
  free running clock and a synchronous, active high reset held
  for the first few rising edges
*/
`timescale 1ns/100ps

module clockGen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 reset = 1'b0; // released just after an edge, like any other input
  end

endmodule

// File: test/privUnitTb.sv
/*
  privilege unit testbench
  replays the operations of the data file against the DUT: CSR
  accesses over the req/ack port, fault and interrupt vectors,
  xret requests and mode checks, with a watchdog on the whole run
*/
`timescale 1ns/100ps
`include "priv_defs.svh"

module privUnitTb;

  localparam int NARGS = 10; // fields stored per operation

  logic               clk, reset;
  logic [15:0]        faults;            // bit n is the fault with exception code n
  logic               instrValidM, committedM, committedF, wfiM, wfiW;
  logic [`XLEN_P-1:0] pcM, csrWdata, csrRdata, redirectPc;
  logic               mretM, sretM;
  logic               extIntM, extIntS, timerIntM, softIntM;
  logic               csrReq, csrWrite, csrAck;
  logic [11:0]        csrAddr;
  logic               trapM, interruptM, exceptionM, intPendingM, delegateM, redirect;
  logic [3:0]         causeM;
  logic [1:0]         privMode;

  logic [7:0]  opCode [$];               // one letter per operation
  logic [31:0] opArgs [$];               // NARGS words per operation
  logic [31:0] rngState;
  int          valueErrs, otherErrs;
  bit          loaded;

  clockGen uClockGen (.clk, .reset);

  privUnit i_dut (
    .clk, .reset,
    .instrMisalignedFault(faults[0]), .instrAccessFault(faults[1]),
    .illegalInstrFault(faults[2]), .breakpointFault(faults[3]),
    .loadMisalignedFault(faults[4]), .loadAccessFault(faults[5]),
    .storeMisalignedFault(faults[6]), .storeAccessFault(faults[7]),
    .ecallFault(faults[8]), .instrPageFault(faults[12]),
    .loadPageFault(faults[13]), .storePageFault(faults[15]),
    .instrValidM, .committedM, .committedF, .wfiM, .wfiW, .pcM, .mretM, .sretM,
    .extIntM, .extIntS, .timerIntM, .softIntM,
    .csrReq, .csrAddr, .csrWrite, .csrWdata, .csrAck, .csrRdata,
    .trapM, .interruptM, .exceptionM, .intPendingM, .delegateM, .causeM,
    .redirect, .redirectPc, .privMode
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshiftStep(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] act,
                            input logic [31:0] exp);
    assert (act === exp) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      valueErrs++;
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #10; // inputs change 10 ns after the edge
  endtask

  task automatic driveIdle(); // no instruction in M, no faults
    faults      = '0;
    instrValidM = 1'b0;
    committedM  = 1'b0;
    committedF  = 1'b0;
    wfiM        = 1'b0;
    wfiW        = 1'b0;
    pcM         = '0;
  endtask

  // reads the whole data file into the op queues
  task automatic loadOps();
    int               fd, n;
    logic [63:0]      tok;
    logic [8*256-1:0] rest;
    logic [31:0]      f [NARGS];
    fd = $fopen("test/privUnit_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      otherErrs++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      foreach (f[k]) f[k] = '0;
      n = 1;
      case (tok[7:0])
        "#": n = $fgets(rest, fd);                 // comment, skip the line
        "C": n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
        "V": n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        "X": n = $fscanf(fd, "%h %h", f[0], f[1]);
        "I", "N", "P": n = $fscanf(fd, "%h", f[0]);
        default: n = 0;
      endcase
      if (n < 1) begin
        $display("test data line for op '%s' could not be parsed", tok);
        otherErrs++;
      end else if (tok[7:0] != "#") begin
        opCode.push_back(tok[7:0]);
        foreach (f[k]) opArgs.push_back(f[k]);
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////////////////////////
  // full four-phase access, optional random hold of csrReq
  task automatic runCsr(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                        input logic [31:0] exp, input logic hold);
    int extra;
    extra = 0;
    if (hold) begin
      rngState = xorshiftStep(rngState);
      extra    = int'(rngState % 4) + 1;
    end
    csrReq   = 1'b1;
    csrAddr  = addr;
    csrWrite = wr;
    csrWdata = data;
    do nextCycle(); while (!csrAck);
    checkValue("csrRdata", csrRdata, exp);            // old value on a write
    repeat (extra) begin
      nextCycle();
      assert (csrAck) else begin
        $display("csrAck dropped at %0t ns while csrReq was still held", $time);
        otherErrs++;
      end
    end
    csrReq = 1'b0;
    do nextCycle(); while (csrAck);
  endtask

  // one M-stage slot, checked mid cycle, trap state taken at the next edge
  task automatic runVector(input int b);
    faults = opArgs[b][15:0];
    {instrValidM, committedM, committedF, wfiM, wfiW} = opArgs[b+1][4:0];
    pcM = opArgs[b+2];
    #40;
    checkValue("trapM", 32'(trapM), opArgs[b+3]);
    checkValue("interruptM", 32'(interruptM), opArgs[b+4]);
    checkValue("exceptionM", 32'(exceptionM), opArgs[b+5]);
    checkValue("intPendingM", 32'(intPendingM), opArgs[b+6]);
    checkValue("causeM", 32'(causeM), opArgs[b+7]);
    checkValue("delegateM", 32'(delegateM), opArgs[b+8]);
    checkValue("redirect", 32'(redirect), opArgs[b+3]);   // only a trap redirects here
    checkValue("redirectPc", redirectPc, opArgs[b+9]);
    nextCycle();
    driveIdle();
  endtask

  task automatic runXret(input logic isMret, input logic [31:0] expPc);
    mretM = isMret;
    sretM = ~isMret;
    #40;
    checkValue("redirect", 32'(redirect), 32'd1);
    checkValue("redirectPc", redirectPc, expPc);        // epc of the mode left
    nextCycle();
    mretM = 1'b0;
    sretM = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int b;
    driveIdle();
    {mretM, sretM} = 2'b00;
    {extIntM, extIntS, timerIntM, softIntM} = 4'h0;
    csrReq    = 1'b0;
    csrWrite  = 1'b0;
    csrAddr   = '0;
    csrWdata  = '0;
    rngState  = 32'hd0a2_77e6;
    valueErrs = 0;
    otherErrs = 0;
    loadOps();
    loaded = 1'b1;
    @(negedge reset);                                   // 10 ns after an edge
    for (int i = 0; i < opCode.size(); i++) begin
      b = i * NARGS;
      case (opCode[i])
        "C": runCsr(opArgs[b][0], opArgs[b+1][11:0], opArgs[b+2], opArgs[b+3],
                    opArgs[b+4][0]);
        "V": runVector(b);
        "X": runXret(opArgs[b][0], opArgs[b+1]);
        "I": {extIntM, extIntS, timerIntM, softIntM} = opArgs[b][3:0];
        "N": repeat (opArgs[b]) nextCycle();
        "P": checkValue("privMode", 32'(privMode), opArgs[b]); // register, already settled
        default: ;
      endcase
    end
    $display("errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog, 20 cycles per operation plus margin
  initial begin
    wait (loaded);
    repeat (opCode.size() * 20 + 100) @(posedge clk);
    $display("watchdog expired, the tests did not finish in %0d cycles",
             opCode.size() * 20 + 100);
    $display("errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
    $display("test failed");
    $finish;
  end

endmodule

// File: test/privUnit_testdata.txt
# C wr addr wdata expRead hold | V faults qual(valid cmtM cmtF wfiM wfiW) pc trap int exc pend cause deleg rpc
# X mret(1)/sret(0) expPc | I lines(extM extS timM softM) | N cycles | P expMode
P 3
C 0 300 00000000 00000000 0
C 1 305 00001003 00000000 1
C 0 305 00000000 00001001 0
C 1 304 ffffffff 00000000 0
C 0 304 00000000 00000aaa 1
C 1 344 ffffffff 00000000 0
C 0 344 00000000 00000222 0
V 0000 10 00000100 0 0 0 1 0 0 00000000
C 1 344 00000000 00000222 0
V 110d 10 00000200 1 0 1 0 c 0 00001000
V 010d 10 00000204 1 0 1 0 2 0 00001000
V 0100 10 0000020c 1 0 1 0 b 0 00001000
V a0f0 10 00000210 1 0 1 0 6 0 00001000
V a0a0 10 00000214 1 0 1 0 f 0 00001000
V 00a0 10 00000240 1 0 1 0 7 0 00001000
C 0 342 00000000 00000007 0
C 0 341 00000000 00000240 0
C 1 300 00000008 00001800 0
I f
N 3
V 0000 18 00000300 0 0 0 1 0 0 00000000
V 0000 14 00000300 0 0 0 1 0 0 00000000
V 0000 12 00000300 0 0 0 1 b 0 00000000
V 0000 00 00000300 0 0 0 1 b 0 00000000
I 7
N 3
V 0000 13 00000300 1 1 0 1 3 0 0000100c
I 0
C 0 342 00000000 80000003 0
C 1 300 00000080 00001880 0
X 1 00000300
P 0
V 0100 10 00000400 1 0 1 0 8 0 00001000
X 1 00000400
P 0
C 0 300 00000000 00000008 0
C 1 302 0000ffff 00000000 0
C 0 302 00000000 0000b3ff 0
C 1 303 ffffffff 00000000 1
C 1 105 00002001 00000000 0
V 0004 10 00000500 1 0 1 0 2 1 00002000
P 1
C 0 141 00000000 00000500 0
C 0 142 00000000 00000002 0
X 0 00000500
P 0
I 4
N 3
V 0000 10 00000600 1 1 0 1 9 1 00002024
C 0 142 00000000 80000009 0
I 0
